// ==== build.f ====
hw/bk_pkg.sv
hw/bk_sector_seq.sv
hw/bk_sector_buf.sv
hw/bk_mem_mover.sv
hw/bk_save_top.sv
verif/bk_save_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the backup RAM testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module bk_save_tb -f build.f --Mdir obj_dir -o bk_save_sim

# the log decides the result, not the exit code
./obj_dir/bk_save_sim > sim.log 2>&1 || true
cat sim.log

grep -q "^Done: no errors$" sim.log
echo "simulation passed"

// ==== verif/bk_save_tb.sv ====
`timescale 1ns/100ps

module bk_save_tb;
	import bk_pkg::*;

	localparam int                SECTOR_COUNT = 16;
	localparam logic [MEM_AW-1:0] MEM_BASE     = 24'hE00000;
	localparam int                IMG_WORDS    = SECTOR_COUNT * (SECTOR_BYTES / 2);
	localparam int                MEM_BYTES    = SECTOR_COUNT * SECTOR_BYTES;
	localparam int                XFER_LIMIT   = 200000;
	localparam int                NUM_ROWS     = 16;

	typedef enum logic [2:0] {
		OP_MOUNT, OP_MOUNT_RO, OP_CHANGE, OP_LOAD, OP_SAVE, OP_AUTOSAVE
	} op_e;

	typedef struct packed {
		op_e  op;
		logic xfer;
		logic pend;
	} row_t;

	// operation, transfer expected, pending afterwards
	localparam row_t STIM_ROWS [NUM_ROWS] = '{
		'{OP_LOAD,     1'b0, 1'b0},
		'{OP_SAVE,     1'b0, 1'b0},
		'{OP_MOUNT_RO, 1'b0, 1'b0},
		'{OP_LOAD,     1'b0, 1'b0},
		'{OP_CHANGE,   1'b0, 1'b1},
		'{OP_MOUNT,    1'b0, 1'b1},
		'{OP_LOAD,     1'b1, 1'b0},
		'{OP_SAVE,     1'b1, 1'b0},
		'{OP_CHANGE,   1'b0, 1'b1},
		'{OP_AUTOSAVE, 1'b1, 1'b0},
		'{OP_AUTOSAVE, 1'b0, 1'b0},
		'{OP_CHANGE,   1'b0, 1'b1},
		'{OP_MOUNT_RO, 1'b0, 1'b1},
		'{OP_SAVE,     1'b0, 1'b1},
		'{OP_MOUNT,    1'b0, 1'b1},
		'{OP_SAVE,     1'b1, 1'b0}
	};

	logic        clk_sys = 1'b0;
	logic        rst_n;
	bk_ctrl_t    ctrl;
	logic        sd_ack;
	sd_buf_t     sd_buf;
	buf_word_u   sd_rdata;
	sd_req_t     sd_req;
	mem_req_t    mem_req;
	logic        mem_busy;
	logic [7:0]  mem_rdata;
	logic        pending;
	logic        busy;
	logic [15:0] lfsr = 16'd26323;

	// model contents and the expected copies
	buf_word_u  sd_img  [IMG_WORDS];
	buf_word_u  exp_img [IMG_WORDS];
	logic [7:0] mem_arr [MEM_BYTES];
	logic [7:0] exp_mem [MEM_BYTES];

	always #2 clk_sys = ~clk_sys;

	bk_save_top #(
		.SECTOR_COUNT(SECTOR_COUNT),
		.MEM_BASE    (MEM_BASE)
	) i_dut (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.ctrl     (ctrl),
		.sd_ack   (sd_ack),
		.sd_buf   (sd_buf),
		.sd_rdata (sd_rdata),
		.sd_req   (sd_req),
		.mem_req  (mem_req),
		.mem_busy (mem_busy),
		.mem_rdata(mem_rdata),
		.pending  (pending),
		.busy     (busy)
	);

	//////////////////////////////
	// helpers
	//////////////////////////////

	// fibonacci lfsr with taps 16 14 13 11
	function automatic int rand_bits(input int n);
		int r;
		int i;
		r = 0;
		for (i = 0; i < n; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			r = (r << 1) | int'(lfsr[0]);
		end
		return r;
	endfunction

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input int idx, input buf_word_u got,
			input buf_word_u exp);
		if (got !== exp) begin
			stop_with_error($sformatf("[ERROR] %s[%0d]: got %h, expected %h",
				name, idx, got.word, exp.word));
		end
	endtask

	task automatic check_byte(input string name, input int idx, input logic [7:0] got,
			input logic [7:0] exp);
		if (got !== exp) begin
			stop_with_error($sformatf("[ERROR] %s[%0d]: got %h, expected %h",
				name, idx, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			stop_with_error($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic wait_busy(input logic level, input int limit);
		int n;
		n = 0;
		while (busy !== level) begin
			if (n >= limit) begin
				stop_with_error($sformatf("timeout while waiting for busy to become %0b", level));
			end
			@(posedge clk_sys);
			#1;
			n++;
		end
	endtask

	// nothing may start while disabled or idle
	task automatic watch_idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk_sys);
			#1;
			check_flag("sd_req.rd", sd_req.rd, 1'b0);
			check_flag("sd_req.wr", sd_req.wr, 1'b0);
			check_flag("busy", busy, 1'b0);
		end
	endtask

	task automatic pulse_ctrl(input op_e op);
		bk_ctrl_t c;
		c = '0;
		case (op)
			OP_MOUNT:    c.mounted = 1'b1;
			OP_MOUNT_RO: begin
				c.mounted  = 1'b1;
				c.readonly = 1'b1;
			end
			OP_CHANGE:   c.change = 1'b1;
			OP_LOAD:     c.load = 1'b1;
			OP_SAVE:     c.save = 1'b1;
			default:     c.autosave = 1'b1;
		endcase
		@(posedge clk_sys);
		#1;
		ctrl = c;
		@(posedge clk_sys);
		#1;
		ctrl = '0;
	endtask

	task automatic compare_models();
		int i;
		for (i = 0; i < IMG_WORDS; i++) begin
			check_word("sd_img", i, sd_img[i], exp_img[i]);
		end
		for (i = 0; i < MEM_BYTES; i++) begin
			check_byte("mem", i, mem_arr[i], exp_mem[i]);
		end
	endtask

	//////////////////////////////
	// sd host model
	//////////////////////////////

	initial begin : sd_host
		int   state;
		int   cnt;
		int   w;
		int   base;
		logic is_rd;
		sd_ack = 1'b0;
		sd_buf = '0;
		state  = 0;
		forever begin
			@(posedge clk_sys);
			#1;
			if (state == 0) begin
				if (sd_req.rd || sd_req.wr) begin
					if (int'(sd_req.lba) >= SECTOR_COUNT) begin
						stop_with_error("SD request for a sector outside the image");
					end
					base  = int'(sd_req.lba) * (SECTOR_BYTES / 2);
					is_rd = sd_req.rd;
					cnt   = rand_bits(2);
					state = 1;
				end
			end else if (state == 1) begin
				// late ack
				if (cnt == 0) begin
					sd_ack = 1'b1;
					w      = 0;
					state  = 2;
				end else begin
					cnt--;
				end
			end else if (is_rd) begin
				if (w < SECTOR_BYTES / 2) begin
					sd_buf.addr  = WORD_AW'(w);
					sd_buf.wdata = sd_img[base + w].word;
					sd_buf.wr    = 1'b1;
					w++;
				end else begin
					sd_buf.wr = 1'b0;
					sd_ack    = 1'b0;
					state     = 0;
				end
			end else begin
				// read data trails the address by one cycle
				if (w > 0) begin
					sd_img[base + w - 1] = sd_rdata;
				end
				if (w < SECTOR_BYTES / 2) begin
					sd_buf.addr = WORD_AW'(w);
					w++;
				end else begin
					sd_ack = 1'b0;
					state  = 0;
				end
			end
		end
	end

	//////////////////////////////
	// memory model
	//////////////////////////////

	initial begin : mem_model
		int   cnt;
		int   off;
		logic is_rd;
		mem_busy  = 1'b0;
		mem_rdata = '0;
		forever begin
			@(posedge clk_sys);
			#1;
			if (!mem_busy) begin
				if (mem_req.rd || mem_req.wr) begin
					off = int'(mem_req.addr - MEM_BASE);
					if (off >= MEM_BYTES) begin
						stop_with_error("memory access outside the save RAM");
					end
					is_rd = mem_req.rd;
					if (mem_req.wr) begin
						mem_arr[off] = mem_req.wdata;
					end
					cnt      = 1 + rand_bits(2);
					mem_busy = 1'b1;
				end
			end else begin
				cnt--;
				if (cnt == 0) begin
					mem_busy = 1'b0;
					if (is_rd) begin
						mem_rdata = mem_arr[off];
					end
				end
			end
		end
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////

	initial begin : main
		row_t row;
		int   r;
		int   i;
		rst_n = 1'b0;
		ctrl  = '0;
		for (i = 0; i < IMG_WORDS; i++) begin
			exp_img[i].word = 16'(rand_bits(16));
			sd_img[i]       = exp_img[i];
		end
		for (i = 0; i < MEM_BYTES; i++) begin
			exp_mem[i] = 8'(rand_bits(8));
			mem_arr[i] = exp_mem[i];
		end
		repeat (5) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;

		check_flag("sd_req.rd", sd_req.rd, 1'b0);
		check_flag("sd_req.wr", sd_req.wr, 1'b0);
		check_flag("mem_req.rd", mem_req.rd, 1'b0);
		check_flag("mem_req.wr", mem_req.wr, 1'b0);
		check_flag("busy", busy, 1'b0);
		check_flag("pending", pending, 1'b0);

		for (r = 0; r < NUM_ROWS; r++) begin
			row = STIM_ROWS[r];
			$display("row %0d: %s", r, row.op.name());
			// fresh source data for every load or save
			if (row.op == OP_LOAD) begin
				for (i = 0; i < IMG_WORDS; i++) begin
					exp_img[i].word = 16'(rand_bits(16));
					sd_img[i]       = exp_img[i];
				end
			end else if (row.op == OP_SAVE || row.op == OP_AUTOSAVE) begin
				for (i = 0; i < MEM_BYTES; i++) begin
					exp_mem[i] = 8'(rand_bits(8));
					mem_arr[i] = exp_mem[i];
				end
			end

			pulse_ctrl(row.op);

			if (row.xfer) begin
				wait_busy(1'b1, 4);
				wait_busy(1'b0, XFER_LIMIT);
				// byte 0 of a word is its low byte
				for (i = 0; i < MEM_BYTES; i++) begin
					if (row.op == OP_LOAD) begin
						exp_mem[i] = (i % 2 == 0) ? exp_img[i / 2].word[7:0]
							: exp_img[i / 2].word[15:8];
					end else if (i % 2 == 0) begin
						exp_img[i / 2].word[7:0] = exp_mem[i];
					end else begin
						exp_img[i / 2].word[15:8] = exp_mem[i];
					end
				end
			end else begin
				watch_idle(20);
			end

			check_flag("busy", busy, 1'b0);
			check_flag("pending", pending, row.pend);
			compare_models();
		end

		$display("Done: no errors");
		$finish;
	end

endmodule

// ==== hw/bk_save_top.sv ====
`timescale 1ns/100ps

module bk_save_top #(
	parameter int                        SECTOR_COUNT = 16,
	parameter logic [bk_pkg::MEM_AW-1:0] MEM_BASE     = 24'hE00000
) (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  bk_pkg::bk_ctrl_t  ctrl,
	input  logic              sd_ack,
	input  bk_pkg::sd_buf_t   sd_buf,
	output bk_pkg::buf_word_u sd_rdata,
	output bk_pkg::sd_req_t   sd_req,
	output bk_pkg::mem_req_t  mem_req,
	input  logic              mem_busy,
	input  logic [7:0]        mem_rdata,
	output logic              pending,
	output logic              busy
);
	import bk_pkg::*;

	localparam int SECT_W = $clog2(SECTOR_COUNT);
	localparam int IDX_W  = MEM_AW - BYTE_AW;

	logic               xfer_start;
	logic               xfer_done;
	logic               loading;
	logic [SECT_W-1:0]  sector;
	logic [IDX_W-1:0]   mem_sector;
	logic [BYTE_AW-1:0] byte_addr;
	logic [7:0]         byte_wdata;
	logic               byte_we;
	logic [7:0]         byte_rdata;

	// sector index widened to the memory address space
	assign mem_sector = {{(IDX_W - SECT_W){1'b0}}, sector};

	//////////////////////////////
	// sequencer
	//////////////////////////////

	bk_sector_seq #(
		.SECTOR_COUNT(SECTOR_COUNT)
	) i_seq (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.ctrl      (ctrl),
		.sd_ack    (sd_ack),
		.sd_req    (sd_req),
		.xfer_start(xfer_start),
		.loading   (loading),
		.sector    (sector),
		.xfer_done (xfer_done),
		.pending   (pending),
		.busy      (busy)
	);

	//////////////////////////////
	// sector buffer
	//////////////////////////////

	bk_sector_buf i_buf (
		.clk_sys   (clk_sys),
		.sd_buf    (sd_buf),
		.sd_rdata  (sd_rdata),
		.byte_addr (byte_addr),
		.byte_wdata(byte_wdata),
		.byte_we   (byte_we),
		.byte_rdata(byte_rdata)
	);

	//////////////////////////////
	// memory side
	//////////////////////////////

	bk_mem_mover #(
		.MEM_BASE(MEM_BASE)
	) i_mover (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.xfer_start(xfer_start),
		.loading   (loading),
		.sector    (mem_sector),
		.xfer_done (xfer_done),
		.byte_addr (byte_addr),
		.byte_wdata(byte_wdata),
		.byte_we   (byte_we),
		.byte_rdata(byte_rdata),
		.mem_req   (mem_req),
		.mem_busy  (mem_busy),
		.mem_rdata (mem_rdata)
	);

endmodule

// ==== hw/bk_mem_mover.sv ====
`timescale 1ns/100ps

module bk_mem_mover #(
	parameter logic [bk_pkg::MEM_AW-1:0] MEM_BASE = 24'hE00000
) (
	input  logic                                      clk_sys,
	input  logic                                      rst_n,
	input  logic                                      xfer_start,
	input  logic                                      loading,
	input  logic [bk_pkg::MEM_AW-bk_pkg::BYTE_AW-1:0] sector,
	output logic                                      xfer_done,
	output logic [bk_pkg::BYTE_AW-1:0]                byte_addr,
	output logic [7:0]                                byte_wdata,
	output logic                                      byte_we,
	input  logic [7:0]                                byte_rdata,
	output bk_pkg::mem_req_t                          mem_req,
	input  logic                                      mem_busy,
	input  logic [7:0]                                mem_rdata
);
	import bk_pkg::*;

	localparam logic [BYTE_AW-1:0] LAST_BYTE = BYTE_AW'(SECTOR_BYTES - 1);

	// per-byte phases
	localparam logic [1:0] PH_ADDR = 2'd0;
	localparam logic [1:0] PH_REQ  = 2'd1;
	localparam logic [1:0] PH_WAIT = 2'd2;

	logic [1:0] phase;
	logic       busy_q;
	logic       busy_fall;

	assign busy_fall = busy_q & ~mem_busy;

	// save path, memory byte straight into the buffer as busy falls
	assign byte_we    = ~loading & (phase == PH_WAIT) & busy_fall;
	assign byte_wdata = mem_rdata;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			phase     <= PH_ADDR;
			byte_addr <= '0;
			xfer_done <= 1'b0;
			busy_q    <= 1'b0;
			mem_req   <= '0;
		end else begin
			busy_q <= mem_busy;

			// request taken once memory reports busy
			if (mem_busy) begin
				mem_req.rd <= 1'b0;
				mem_req.wr <= 1'b0;
			end

			if (!xfer_start) begin
				phase     <= PH_ADDR;
				byte_addr <= '0;
				xfer_done <= 1'b0;
			end else if (!xfer_done) begin
				case (phase)
					// buffer read of byte_addr in flight
					PH_ADDR: phase <= PH_REQ;
					PH_REQ: begin
						mem_req.addr  <= MEM_BASE + {sector, byte_addr};
						mem_req.wdata <= byte_rdata;
						mem_req.rd    <= ~loading;
						mem_req.wr    <= loading;
						phase         <= PH_WAIT;
					end
					PH_WAIT: begin
						if (busy_fall) begin
							phase <= PH_ADDR;
							if (byte_addr == LAST_BYTE) begin
								xfer_done <= 1'b1;
							end else begin
								byte_addr <= byte_addr + 1'b1;
							end
						end
					end
					default: phase <= PH_ADDR;
				endcase
			end
		end
	end

	a_mem_rd_wr_excl: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		!(mem_req.rd && mem_req.wr)
	);

endmodule

// ==== hw/bk_sector_buf.sv ====
`timescale 1ns/100ps

module bk_sector_buf (
	input  logic                       clk_sys,
	input  bk_pkg::sd_buf_t            sd_buf,
	output bk_pkg::buf_word_u          sd_rdata,
	input  logic [bk_pkg::BYTE_AW-1:0] byte_addr,
	input  logic [7:0]                 byte_wdata,
	input  logic                       byte_we,
	output logic [7:0]                 byte_rdata
);
	import bk_pkg::*;

	localparam int WORDS = SECTOR_BYTES / 2;

	// one sector, word wide
	buf_word_u mem [WORDS];

	logic [WORD_AW-1:0] word_idx;
	logic               hi_sel;

	assign word_idx = byte_addr[BYTE_AW-1:1];
	assign hi_sel   = byte_addr[0];

	// both ports in one process, byte port updates half a word
	always_ff @(posedge clk_sys) begin
		if (sd_buf.wr) begin
			mem[sd_buf.addr].word <= sd_buf.wdata;
		end
		if (byte_we) begin
			if (hi_sel) begin
				mem[word_idx].bytes.hi <= byte_wdata;
			end else begin
				mem[word_idx].bytes.lo <= byte_wdata;
			end
		end

		// registered reads, one cycle latency
		sd_rdata <= mem[sd_buf.addr];
		if (hi_sel) begin
			byte_rdata <= mem[word_idx].bytes.hi;
		end else begin
			byte_rdata <= mem[word_idx].bytes.lo;
		end
	end

	// sd phase and memory phase never overlap on a word
	a_no_write_clash: assert property (
		@(posedge clk_sys)
		(sd_buf.wr && byte_we) |-> (sd_buf.addr != word_idx)
	);

endmodule

// ==== hw/bk_sector_seq.sv ====
`timescale 1ns/100ps

module bk_sector_seq #(
	parameter int SECTOR_COUNT = 16
) (
	input  logic                            clk_sys,
	input  logic                            rst_n,
	input  bk_pkg::bk_ctrl_t                ctrl,
	input  logic                            sd_ack,
	output bk_pkg::sd_req_t                 sd_req,
	output logic                            xfer_start,
	output logic                            loading,
	output logic [$clog2(SECTOR_COUNT)-1:0] sector,
	input  logic                            xfer_done,
	output logic                            pending,
	output logic                            busy
);
	import bk_pkg::*;

	localparam int SECT_W = $clog2(SECTOR_COUNT);

	// per-sector steps, meaning depends on direction
	localparam logic [1:0] STEP_FIRST = 2'd0;
	localparam logic [1:0] STEP_MID   = 2'd1;
	localparam logic [1:0] STEP_LAST  = 2'd2;

	bk_ctrl_t   ctrl_q;
	logic       ack_q;
	logic       ena;
	logic [1:0] step;
	logic       last_sector;
	logic       ack_rise;
	logic       ack_fall;
	logic       load_edge;
	logic       save_edge;
	logic       asave_edge;
	logic       start;

	//////////////////////////////
	// triggers
	//////////////////////////////

	assign ack_rise   = sd_ack & ~ack_q;
	assign ack_fall   = ~sd_ack & ack_q;
	assign load_edge  = ctrl.load & ~ctrl_q.load;
	assign save_edge  = ctrl.save & ~ctrl_q.save;
	assign asave_edge = ctrl.autosave & ~ctrl_q.autosave;

	// autosave only worth doing with unsaved changes
	assign start = ena & ~busy & (load_edge | save_edge | (asave_edge & pending));

	assign sector      = sd_req.lba[SECT_W-1:0];
	assign last_sector = &sector;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_q <= '0;
			ack_q  <= 1'b0;
		end else begin
			ctrl_q <= ctrl;
			ack_q  <= sd_ack;
		end
	end

	// writable image mounted enables the engine
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ena     <= 1'b0;
			pending <= 1'b0;
		end else begin
			if (ctrl.mounted) begin
				ena <= ~ctrl.readonly;
			end
			// a change during a transfer stays pending
			if (ctrl.change) begin
				pending <= 1'b1;
			end else if (start) begin
				pending <= 1'b0;
			end
		end
	end

	//////////////////////////////
	// sector loop
	//////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			sd_req     <= '0;
			busy       <= 1'b0;
			loading    <= 1'b0;
			xfer_start <= 1'b0;
			step       <= STEP_FIRST;
		end else begin
			// host took the command
			if (ack_rise) begin
				sd_req.rd <= 1'b0;
				sd_req.wr <= 1'b0;
			end

			if (!busy) begin
				step       <= STEP_FIRST;
				sd_req.lba <= '0;
				xfer_start <= 1'b0;
				if (start) begin
					busy    <= 1'b1;
					loading <= load_edge;
				end
			end else if (loading) begin
				// sd read, then buffer to memory
				case (step)
					STEP_FIRST: begin
						sd_req.rd <= 1'b1;
						step      <= STEP_MID;
					end
					STEP_MID: begin
						if (ack_fall) begin
							xfer_start <= 1'b1;
							step       <= STEP_LAST;
						end
					end
					STEP_LAST: begin
						if (xfer_done) begin
							xfer_start <= 1'b0;
							step       <= STEP_FIRST;
							sd_req.lba <= sd_req.lba + 16'd1;
							if (last_sector) begin
								busy <= 1'b0;
							end
						end
					end
					default: step <= STEP_FIRST;
				endcase
			end else begin
				// memory to buffer, then sd write
				case (step)
					STEP_FIRST: begin
						xfer_start <= 1'b1;
						step       <= STEP_MID;
					end
					STEP_MID: begin
						if (xfer_done) begin
							xfer_start <= 1'b0;
							sd_req.wr  <= 1'b1;
							step       <= STEP_LAST;
						end
					end
					STEP_LAST: begin
						if (ack_fall) begin
							step       <= STEP_FIRST;
							sd_req.lba <= sd_req.lba + 16'd1;
							if (last_sector) begin
								busy <= 1'b0;
							end
						end
					end
					default: step <= STEP_FIRST;
				endcase
			end
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	// only one sd command outstanding
	a_sd_rd_wr_excl: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		!(sd_req.rd && sd_req.wr)
	);

	// mover runs only inside a transfer
	a_start_in_busy: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		$rose(xfer_start) |-> busy
	);

endmodule

// ==== hw/bk_pkg.sv ====
package bk_pkg;

	//////////////////////////////
	// sizes
	//////////////////////////////

	// fixed by the sd sector format
	localparam int SECTOR_BYTES = 512;
	localparam int BYTE_AW      = $clog2(SECTOR_BYTES);
	localparam int WORD_AW      = BYTE_AW - 1;

	// byte address space of the cart memory
	localparam int MEM_AW = 24;

	//////////////////////////////
	// sd host side
	//////////////////////////////

	// sector request, rd/wr held until ack rises
	typedef struct packed {
		logic [15:0] lba;
		logic        rd;
		logic        wr;
	} sd_req_t;

	// host access to the sector buffer while ack is high
	typedef struct packed {
		logic [WORD_AW-1:0] addr;
		logic [15:0]        wdata;
		logic               wr;
	} sd_buf_t;

	// byte 0 of a word sits in the low half
	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} buf_bytes_t;

	// whole word on the sd port, two bytes on the memory port
	typedef union packed {
		logic [15:0] word;
		buf_bytes_t  bytes;
	} buf_word_u;

	//////////////////////////////
	// memory side and control
	//////////////////////////////

	typedef struct packed {
		logic [MEM_AW-1:0] addr;
		logic [7:0]        wdata;
		logic              rd;
		logic              wr;
	} mem_req_t;

	// mounted and change are single-cycle pulses
	typedef struct packed {
		logic load;
		logic save;
		logic autosave;
		logic mounted;
		logic readonly;
		logic change;
	} bk_ctrl_t;

endpackage
